//--- verilog/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OP_WIDTH       = 8;
    localparam int SHAMT_WIDTH    = 5;

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [2*DATA_WIDTH-1:0]   dword_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // operator codes as issued by the decoder.
    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP   = 8'h00,
        // logic.
        OP_AND   = 8'h01,
        OP_OR    = 8'h02,
        OP_XOR   = 8'h03,
        OP_NOR   = 8'h04,
        // shift.
        OP_SLL   = 8'h05,
        OP_SRL   = 8'h06,
        OP_SRA   = 8'h07,
        // move and hi/lo access.
        OP_MFHI  = 8'h08,
        OP_MFLO  = 8'h09,
        OP_MTHI  = 8'h0a,
        OP_MTLO  = 8'h0b,
        OP_MOVN  = 8'h0c,
        OP_MOVZ  = 8'h0d,
        // arithmetic.
        OP_ADD   = 8'h0e,
        OP_ADDU  = 8'h0f,
        OP_SUB   = 8'h10,
        OP_SUBU  = 8'h11,
        OP_SLT   = 8'h12,
        OP_SLTU  = 8'h13,
        OP_CLZ   = 8'h14,
        OP_CLO   = 8'h15,
        // multiply.
        OP_MULT  = 8'h16,
        OP_MULTU = 8'h17,
        OP_MUL   = 8'h18
    } alu_op_t;

    // result group of an operator, picks the source of the register result.
    typedef enum logic [2:0] {
        CAT_NONE  = 3'd0,
        CAT_LOGIC = 3'd1,
        CAT_SHIFT = 3'd2,
        CAT_MOVE  = 3'd3,
        CAT_ARITH = 3'd4
    } op_category_t;

endpackage

`default_nettype wire

//--- verilog/ex_logic_shift_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ex_logic_shift_unit (
    input  wire ex_pkg::alu_op_t operator_i,
    input  wire ex_pkg::word_t   operand_a_i,
    input  wire ex_pkg::word_t   operand_b_i,
    output ex_pkg::word_t        logic_result_o,
    output ex_pkg::word_t        shift_result_o
);

    logic [ex_pkg::SHAMT_WIDTH-1:0] shift_amount;

    // the shift amount sits in the low bits of operand a.
    assign shift_amount = operand_a_i[ex_pkg::SHAMT_WIDTH-1:0];

    always_comb begin
        case (operator_i)
            ex_pkg::OP_AND: begin
                logic_result_o = operand_a_i & operand_b_i;
            end
            ex_pkg::OP_OR: begin
                logic_result_o = operand_a_i | operand_b_i;
            end
            ex_pkg::OP_XOR: begin
                logic_result_o = operand_a_i ^ operand_b_i;
            end
            ex_pkg::OP_NOR: begin
                logic_result_o = ~(operand_a_i | operand_b_i);
            end
            default: begin
                logic_result_o = '0;
            end
        endcase
    end

    always_comb begin
        case (operator_i)
            ex_pkg::OP_SLL: begin
                shift_result_o = operand_b_i << shift_amount;
            end
            ex_pkg::OP_SRL: begin
                shift_result_o = operand_b_i >> shift_amount;
            end
            ex_pkg::OP_SRA: begin
                // arithmetic shift keeps the sign of operand b.
                shift_result_o = ex_pkg::word_t'($signed(operand_b_i) >>> shift_amount);
            end
            default: begin
                shift_result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ex_arith_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ex_arith_unit (
    input  wire ex_pkg::alu_op_t operator_i,
    input  wire ex_pkg::word_t   operand_a_i,
    input  wire ex_pkg::word_t   operand_b_i,
    output ex_pkg::word_t        arith_result_o,
    output logic                 overflow_o
);

    logic                          subtract;
    ex_pkg::word_t                 adder_b;
    logic [ex_pkg::DATA_WIDTH:0]   adder_out;
    ex_pkg::word_t                 sum;
    logic                          carry_out;
    logic                          signed_overflow;
    logic                          less_signed;
    logic                          less_unsigned;
    logic                          count_ones;
    ex_pkg::word_t                 lead_source;
    ex_pkg::word_t                 lead_count;

    // compares go through the subtractor as well.
    always_comb begin
        case (operator_i)
            ex_pkg::OP_SUB,
            ex_pkg::OP_SUBU,
            ex_pkg::OP_SLT,
            ex_pkg::OP_SLTU: begin
                subtract = 1'b1;
            end
            default: begin
                subtract = 1'b0;
            end
        endcase
    end

    // one adder, b inverted plus a carry in gives a - b.
    assign adder_b   = subtract ? ~operand_b_i : operand_b_i;
    assign adder_out = {1'b0, operand_a_i} + {1'b0, adder_b}
                     + {{ex_pkg::DATA_WIDTH{1'b0}}, subtract};
    assign sum       = adder_out[ex_pkg::DATA_WIDTH-1:0];
    assign carry_out = adder_out[ex_pkg::DATA_WIDTH];

    // operands of equal sign giving a sum of the other sign.
    assign signed_overflow =
        (operand_a_i[ex_pkg::DATA_WIDTH-1] == adder_b[ex_pkg::DATA_WIDTH-1]) &&
        (sum[ex_pkg::DATA_WIDTH-1] != operand_a_i[ex_pkg::DATA_WIDTH-1]);

    assign less_signed   = sum[ex_pkg::DATA_WIDTH-1] ^ signed_overflow;
    // no borrow out of a - b means a >= b.
    assign less_unsigned = ~carry_out;

    // clo is clz of the inverted operand.
    assign count_ones  = (operator_i == ex_pkg::OP_CLO);
    assign lead_source = count_ones ? ~operand_a_i : operand_a_i;

    // highest set bit wins, so scan upwards and keep the last hit.
    always_comb begin
        lead_count = ex_pkg::word_t'(ex_pkg::DATA_WIDTH);
        for (int i = 0; i < ex_pkg::DATA_WIDTH; i++) begin
            if (lead_source[i]) begin
                lead_count = ex_pkg::word_t'(ex_pkg::DATA_WIDTH - 1 - i);
            end
        end
    end

    always_comb begin
        case (operator_i)
            ex_pkg::OP_ADD,
            ex_pkg::OP_ADDU,
            ex_pkg::OP_SUB,
            ex_pkg::OP_SUBU: begin
                arith_result_o = sum;
            end
            ex_pkg::OP_SLT: begin
                arith_result_o = ex_pkg::word_t'(less_signed);
            end
            ex_pkg::OP_SLTU: begin
                arith_result_o = ex_pkg::word_t'(less_unsigned);
            end
            ex_pkg::OP_CLZ,
            ex_pkg::OP_CLO: begin
                arith_result_o = lead_count;
            end
            default: begin
                arith_result_o = '0;
            end
        endcase
    end

    // only the trapping forms report overflow.
    assign overflow_o = signed_overflow &&
                        ((operator_i == ex_pkg::OP_ADD) || (operator_i == ex_pkg::OP_SUB));

endmodule

`default_nettype wire

//--- verilog/ex_mult_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mult_unit (
    input  wire ex_pkg::alu_op_t operator_i,
    input  wire ex_pkg::word_t   operand_a_i,
    input  wire ex_pkg::word_t   operand_b_i,
    output ex_pkg::dword_t       product_o
);

    logic           active;
    logic           signed_op;
    logic           negate;
    ex_pkg::word_t  magnitude_a;
    ex_pkg::word_t  magnitude_b;
    ex_pkg::dword_t magnitude_product;

    always_comb begin
        active    = 1'b0;
        signed_op = 1'b0;
        case (operator_i)
            ex_pkg::OP_MULT,
            ex_pkg::OP_MUL: begin
                active    = 1'b1;
                signed_op = 1'b1;
            end
            ex_pkg::OP_MULTU: begin
                active = 1'b1;
            end
            default: begin
                active = 1'b0;
            end
        endcase
    end

    // signed forms multiply magnitudes, sign is put back afterwards.
    assign magnitude_a = (signed_op && operand_a_i[ex_pkg::DATA_WIDTH-1]) ?
                         ~operand_a_i + 1'b1 : operand_a_i;
    assign magnitude_b = (signed_op && operand_b_i[ex_pkg::DATA_WIDTH-1]) ?
                         ~operand_b_i + 1'b1 : operand_b_i;

    assign magnitude_product = ex_pkg::dword_t'(magnitude_a) * ex_pkg::dword_t'(magnitude_b);

    assign negate = signed_op &&
                    (operand_a_i[ex_pkg::DATA_WIDTH-1] ^ operand_b_i[ex_pkg::DATA_WIDTH-1]);

    assign product_o = !active ? '0 :
                       negate  ? ~magnitude_product + 1'b1 : magnitude_product;

endmodule

`default_nettype wire

//--- verilog/ex_hilo_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ex_hilo_unit (
    input  wire ex_pkg::alu_op_t operator_i,
    input  wire ex_pkg::word_t   operand_a_i,
    input  wire ex_pkg::dword_t  product_i,

    input  wire                  mem_hi_write_enable_i,
    input  wire ex_pkg::word_t   mem_hi_write_data_i,
    input  wire                  mem_lo_write_enable_i,
    input  wire ex_pkg::word_t   mem_lo_write_data_i,

    input  wire                  wb_hi_write_enable_i,
    input  wire ex_pkg::word_t   wb_hi_write_data_i,
    input  wire                  wb_lo_write_enable_i,
    input  wire ex_pkg::word_t   wb_lo_write_data_i,

    input  wire ex_pkg::word_t   hi_read_data_i,
    input  wire ex_pkg::word_t   lo_read_data_i,

    output ex_pkg::word_t        move_result_o,

    output logic                 hi_write_enable_o,
    output ex_pkg::word_t        hi_write_data_o,
    output logic                 lo_write_enable_o,
    output ex_pkg::word_t        lo_write_data_o
);

    ex_pkg::word_t hi_newest;
    ex_pkg::word_t lo_newest;

    // mem stage is younger than wb, so it takes priority.
    assign hi_newest = mem_hi_write_enable_i ? mem_hi_write_data_i :
                       wb_hi_write_enable_i  ? wb_hi_write_data_i  : hi_read_data_i;
    assign lo_newest = mem_lo_write_enable_i ? mem_lo_write_data_i :
                       wb_lo_write_enable_i  ? wb_lo_write_data_i  : lo_read_data_i;

    always_comb begin
        case (operator_i)
            ex_pkg::OP_MFHI: begin
                move_result_o = hi_newest;
            end
            ex_pkg::OP_MFLO: begin
                move_result_o = lo_newest;
            end
            // the condition of movn/movz is resolved in decode.
            ex_pkg::OP_MOVN,
            ex_pkg::OP_MOVZ: begin
                move_result_o = operand_a_i;
            end
            default: begin
                move_result_o = '0;
            end
        endcase
    end

    always_comb begin
        hi_write_enable_o = 1'b0;
        hi_write_data_o   = '0;
        lo_write_enable_o = 1'b0;
        lo_write_data_o   = '0;
        case (operator_i)
            ex_pkg::OP_MTHI: begin
                hi_write_enable_o = 1'b1;
                hi_write_data_o   = operand_a_i;
            end
            ex_pkg::OP_MTLO: begin
                lo_write_enable_o = 1'b1;
                lo_write_data_o   = operand_a_i;
            end
            ex_pkg::OP_MULT,
            ex_pkg::OP_MULTU: begin
                hi_write_enable_o = 1'b1;
                hi_write_data_o   = product_i[2*ex_pkg::DATA_WIDTH-1:ex_pkg::DATA_WIDTH];
                lo_write_enable_o = 1'b1;
                lo_write_data_o   = product_i[ex_pkg::DATA_WIDTH-1:0];
            end
            default: begin
                hi_write_enable_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/stage_ex.sv
`timescale 1ns/1ns
`default_nettype none

module stage_ex (
    input  wire                    clock_i,
    input  wire                    arst_n_i,

    input  wire                    valid_i,
    input  wire ex_pkg::alu_op_t   operator_i,
    input  wire ex_pkg::word_t     operand_a_i,
    input  wire ex_pkg::word_t     operand_b_i,

    input  wire                    reg_write_enable_i,
    input  wire ex_pkg::reg_addr_t reg_write_addr_i,

    // hi/lo forwarding from mem.
    input  wire                    mem_hi_write_enable_i,
    input  wire ex_pkg::word_t     mem_hi_write_data_i,
    input  wire                    mem_lo_write_enable_i,
    input  wire ex_pkg::word_t     mem_lo_write_data_i,

    // hi/lo forwarding from wb.
    input  wire                    wb_hi_write_enable_i,
    input  wire ex_pkg::word_t     wb_hi_write_data_i,
    input  wire                    wb_lo_write_enable_i,
    input  wire ex_pkg::word_t     wb_lo_write_data_i,

    input  wire ex_pkg::word_t     hi_read_data_i,
    input  wire ex_pkg::word_t     lo_read_data_i,

    output logic                   valid_o,
    output logic                   reg_write_enable_o,
    output ex_pkg::reg_addr_t      reg_write_addr_o,
    output ex_pkg::word_t          reg_write_data_o,

    output logic                   hi_write_enable_o,
    output ex_pkg::word_t          hi_write_data_o,
    output logic                   lo_write_enable_o,
    output ex_pkg::word_t          lo_write_data_o
);

    ex_pkg::op_category_t category;
    ex_pkg::word_t        logic_result;
    ex_pkg::word_t        shift_result;
    ex_pkg::word_t        arith_result;
    ex_pkg::word_t        move_result;
    ex_pkg::dword_t       product;
    logic                 overflow;
    logic                 hi_write_enable;
    ex_pkg::word_t        hi_write_data;
    logic                 lo_write_enable;
    ex_pkg::word_t        lo_write_data;

    ex_pkg::word_t        reg_write_data_d;
    logic                 reg_write_enable_d;
    logic                 hi_write_enable_d;
    logic                 lo_write_enable_d;

    ex_logic_shift_unit ex_logic_shift_unit_inst (
        .operator_i     (operator_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .logic_result_o (logic_result),
        .shift_result_o (shift_result)
    );

    ex_arith_unit ex_arith_unit_inst (
        .operator_i     (operator_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .arith_result_o (arith_result),
        .overflow_o     (overflow)
    );

    ex_mult_unit ex_mult_unit_inst (
        .operator_i  (operator_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .product_o   (product)
    );

    ex_hilo_unit ex_hilo_unit_inst (
        .operator_i            (operator_i),
        .operand_a_i           (operand_a_i),
        .product_i             (product),
        .mem_hi_write_enable_i (mem_hi_write_enable_i),
        .mem_hi_write_data_i   (mem_hi_write_data_i),
        .mem_lo_write_enable_i (mem_lo_write_enable_i),
        .mem_lo_write_data_i   (mem_lo_write_data_i),
        .wb_hi_write_enable_i  (wb_hi_write_enable_i),
        .wb_hi_write_data_i    (wb_hi_write_data_i),
        .wb_lo_write_enable_i  (wb_lo_write_enable_i),
        .wb_lo_write_data_i    (wb_lo_write_data_i),
        .hi_read_data_i        (hi_read_data_i),
        .lo_read_data_i        (lo_read_data_i),
        .move_result_o         (move_result),
        .hi_write_enable_o     (hi_write_enable),
        .hi_write_data_o       (hi_write_data),
        .lo_write_enable_o     (lo_write_enable),
        .lo_write_data_o       (lo_write_data)
    );

    // mthi, mtlo, mult and multu only touch hi/lo.
    always_comb begin
        case (operator_i)
            ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR, ex_pkg::OP_NOR: begin
                category = ex_pkg::CAT_LOGIC;
            end
            ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA: begin
                category = ex_pkg::CAT_SHIFT;
            end
            ex_pkg::OP_MFHI, ex_pkg::OP_MFLO, ex_pkg::OP_MOVN, ex_pkg::OP_MOVZ: begin
                category = ex_pkg::CAT_MOVE;
            end
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU,
            ex_pkg::OP_SLT, ex_pkg::OP_SLTU, ex_pkg::OP_CLZ, ex_pkg::OP_CLO,
            ex_pkg::OP_MUL: begin
                category = ex_pkg::CAT_ARITH;
            end
            default: begin
                category = ex_pkg::CAT_NONE;
            end
        endcase
    end

    always_comb begin
        case (category)
            ex_pkg::CAT_LOGIC: reg_write_data_d = logic_result;
            ex_pkg::CAT_SHIFT: reg_write_data_d = shift_result;
            ex_pkg::CAT_MOVE:  reg_write_data_d = move_result;
            ex_pkg::CAT_ARITH: begin
                // mul keeps the low word of the product.
                reg_write_data_d = (operator_i == ex_pkg::OP_MUL) ?
                                   product[ex_pkg::DATA_WIDTH-1:0] : arith_result;
            end
            default:           reg_write_data_d = '0;
        endcase
    end

    assign reg_write_enable_d = valid_i && reg_write_enable_i && !overflow;
    assign hi_write_enable_d  = valid_i && hi_write_enable;
    assign lo_write_enable_d  = valid_i && lo_write_enable;

    // ex/mem boundary.
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o            <= 1'b0;
            reg_write_enable_o <= 1'b0;
            reg_write_addr_o   <= '0;
            reg_write_data_o   <= '0;
            hi_write_enable_o  <= 1'b0;
            hi_write_data_o    <= '0;
            lo_write_enable_o  <= 1'b0;
            lo_write_data_o    <= '0;
        end else begin
            valid_o            <= valid_i;
            reg_write_enable_o <= reg_write_enable_d;
            reg_write_addr_o   <= reg_write_addr_i;
            reg_write_data_o   <= reg_write_data_d;
            hi_write_enable_o  <= hi_write_enable_d;
            hi_write_data_o    <= hi_write_enable_d ? hi_write_data : '0;
            lo_write_enable_o  <= lo_write_enable_d;
            lo_write_data_o    <= lo_write_enable_d ? lo_write_data : '0;
        end
    end

endmodule

`default_nettype wire

//--- dv/stage_ex_props.sv
`timescale 1ns/1ns
`default_nettype none

module stage_ex_props (
    input wire                    clock_i,
    input wire                    arst_n_i,
    input wire                    valid_i,
    input wire ex_pkg::alu_op_t   operator_i,
    input wire ex_pkg::word_t     operand_a_i,
    input wire ex_pkg::word_t     operand_b_i,
    input wire                    reg_write_enable_i,
    input wire ex_pkg::reg_addr_t reg_write_addr_i,
    input wire                    mem_hi_write_enable_i,
    input wire ex_pkg::word_t     mem_hi_write_data_i,
    input wire                    mem_lo_write_enable_i,
    input wire ex_pkg::word_t     mem_lo_write_data_i,
    input wire                    wb_hi_write_enable_i,
    input wire ex_pkg::word_t     wb_hi_write_data_i,
    input wire                    wb_lo_write_enable_i,
    input wire ex_pkg::word_t     wb_lo_write_data_i,
    input wire ex_pkg::word_t     hi_read_data_i,
    input wire ex_pkg::word_t     lo_read_data_i,
    input wire                    valid_o,
    input wire                    reg_write_enable_o,
    input wire ex_pkg::reg_addr_t reg_write_addr_o,
    input wire ex_pkg::word_t     reg_write_data_o,
    input wire                    hi_write_enable_o,
    input wire ex_pkg::word_t     hi_write_data_o,
    input wire                    lo_write_enable_o,
    input wire ex_pkg::word_t     lo_write_data_o
);

    int unsigned    error_count = 0;
    ex_pkg::dword_t signed_product;
    ex_pkg::dword_t unsigned_product;
    ex_pkg::dword_t hilo_product;
    ex_pkg::dword_t sra_wide;
    logic [32:0]    wide_sum;
    logic [32:0]    wide_diff;
    ex_pkg::word_t  hi_newest;
    ex_pkg::word_t  lo_newest;
    logic           mult_op;
    ex_pkg::word_t  expected_data;
    logic           expected_overflow;
    logic           expected_hi_enable;
    logic           expected_lo_enable;
    ex_pkg::word_t  expected_hi_data;
    ex_pkg::word_t  expected_lo_data;

    // counts matching bits from the msb down.
    function automatic ex_pkg::word_t count_leading(input ex_pkg::word_t value, input logic level);
        int count;
        count = 0;
        while (count < 32 && value[31 - count] == level) begin
            count++;
        end
        return ex_pkg::word_t'(count);
    endfunction

    assign signed_product   = $signed({{32{operand_a_i[31]}}, operand_a_i})
                            * $signed({{32{operand_b_i[31]}}, operand_b_i});
    assign unsigned_product = {32'b0, operand_a_i} * {32'b0, operand_b_i};
    assign sra_wide         = {{32{operand_b_i[31]}}, operand_b_i} >> operand_a_i[4:0];

    // a copy of the sign bit on top, overflow shows as a mismatch of the two.
    assign wide_sum  = {operand_a_i[31], operand_a_i} + {operand_b_i[31], operand_b_i};
    assign wide_diff = {operand_a_i[31], operand_a_i} - {operand_b_i[31], operand_b_i};

    // newest hi/lo, mem ahead of wb ahead of the committed value.
    always_comb begin
        if (mem_hi_write_enable_i) begin
            hi_newest = mem_hi_write_data_i;
        end else if (wb_hi_write_enable_i) begin
            hi_newest = wb_hi_write_data_i;
        end else begin
            hi_newest = hi_read_data_i;
        end
        if (mem_lo_write_enable_i) begin
            lo_newest = mem_lo_write_data_i;
        end else if (wb_lo_write_enable_i) begin
            lo_newest = wb_lo_write_data_i;
        end else begin
            lo_newest = lo_read_data_i;
        end
    end

    assign mult_op            = operator_i == ex_pkg::OP_MULT || operator_i == ex_pkg::OP_MULTU;
    assign hilo_product       = operator_i == ex_pkg::OP_MULTU ? unsigned_product : signed_product;
    assign expected_hi_enable = operator_i == ex_pkg::OP_MTHI || mult_op;
    assign expected_lo_enable = operator_i == ex_pkg::OP_MTLO || mult_op;
    assign expected_hi_data   = operator_i == ex_pkg::OP_MTHI ? operand_a_i :
                                mult_op ? hilo_product[63:32] : '0;
    assign expected_lo_data   = operator_i == ex_pkg::OP_MTLO ? operand_a_i :
                                mult_op ? hilo_product[31:0] : '0;

    always_comb begin
        expected_overflow = 1'b0;
        case (operator_i)
            ex_pkg::OP_AND:  expected_data = operand_a_i & operand_b_i;
            ex_pkg::OP_OR:   expected_data = operand_a_i | operand_b_i;
            ex_pkg::OP_XOR:  expected_data = operand_a_i ^ operand_b_i;
            ex_pkg::OP_NOR:  expected_data = ~(operand_a_i | operand_b_i);
            ex_pkg::OP_SLL:  expected_data = operand_b_i << operand_a_i[4:0];
            ex_pkg::OP_SRL:  expected_data = operand_b_i >> operand_a_i[4:0];
            ex_pkg::OP_SRA:  expected_data = sra_wide[31:0];
            ex_pkg::OP_MFHI: expected_data = hi_newest;
            ex_pkg::OP_MFLO: expected_data = lo_newest;
            ex_pkg::OP_MOVN,
            ex_pkg::OP_MOVZ: expected_data = operand_a_i;
            ex_pkg::OP_ADD: begin
                expected_data     = wide_sum[31:0];
                expected_overflow = wide_sum[32] != wide_sum[31];
            end
            ex_pkg::OP_ADDU: expected_data = wide_sum[31:0];
            ex_pkg::OP_SUB: begin
                expected_data     = wide_diff[31:0];
                expected_overflow = wide_diff[32] != wide_diff[31];
            end
            ex_pkg::OP_SUBU: expected_data = wide_diff[31:0];
            ex_pkg::OP_SLT:  expected_data = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
            ex_pkg::OP_SLTU: expected_data = {31'b0, operand_a_i < operand_b_i};
            ex_pkg::OP_CLZ:  expected_data = count_leading(operand_a_i, 1'b0);
            ex_pkg::OP_CLO:  expected_data = count_leading(operand_a_i, 1'b1);
            ex_pkg::OP_MUL:  expected_data = signed_product[31:0];
            default:         expected_data = '0;
        endcase
    end

    reset_values: assert property (@(posedge clock_i) $rose(arst_n_i) |->
        !(valid_o || reg_write_enable_o || hi_write_enable_o || lo_write_enable_o)
        && reg_write_addr_o == '0 && reg_write_data_o == '0
        && hi_write_data_o == '0 && lo_write_data_o == '0)
        else begin
            error_count++;
            $error("ERR %0t: outputs not cleared after reset", $time);
        end

    idle_cycle: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        !$past(valid_i) |->
        !(valid_o || reg_write_enable_o || hi_write_enable_o || lo_write_enable_o))
        else begin
            error_count++;
            $error("ERR %0t: strobe or write enable high after an idle cycle", $time);
        end

    register_result: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        $past(valid_i) |-> valid_o && reg_write_data_o == $past(expected_data)
        && reg_write_addr_o == $past(reg_write_addr_i))
        else begin
            error_count++;
            $error("ERR %0t: wrong result, data %h addr %0d", $time,
                   $sampled(reg_write_data_o), $sampled(reg_write_addr_o));
        end

    register_enable: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        $past(valid_i) |->
        reg_write_enable_o == $past(reg_write_enable_i && !expected_overflow))
        else begin
            error_count++;
            $error("ERR %0t: wrong reg_write_enable_o %b", $time, $sampled(reg_write_enable_o));
        end

    hilo_write: assert property (@(posedge clock_i) disable iff (!arst_n_i)
        $past(valid_i) |->
        hi_write_enable_o == $past(expected_hi_enable) && hi_write_data_o == $past(expected_hi_data)
        && lo_write_enable_o == $past(expected_lo_enable)
        && lo_write_data_o == $past(expected_lo_data))
        else begin
            error_count++;
            $error("ERR %0t: wrong hi/lo write, hi %h lo %h", $time,
                   $sampled(hi_write_data_o), $sampled(lo_write_data_o));
        end

endmodule

`default_nettype wire

//--- dv/stage_ex_tb.sv
`timescale 1ns/1ns
`default_nettype none

module stage_ex_tb;

    localparam int  NUM_OPS      = 400;
    localparam int  RESET_CYCLES = 4;
    // reset, every operation and the drain, with half again as margin.
    localparam int  MAX_CYCLES   = (RESET_CYCLES + NUM_OPS) * 3 / 2;
    localparam time HALF_PERIOD  = 50;
    localparam time DRIVE_DELAY  = 5;

    logic              clock_i;
    logic              arst_n_i;
    logic              valid_i;
    ex_pkg::alu_op_t   operator_i;
    ex_pkg::word_t     operand_a_i;
    ex_pkg::word_t     operand_b_i;
    logic              reg_write_enable_i;
    ex_pkg::reg_addr_t reg_write_addr_i;
    logic              mem_hi_write_enable_i;
    ex_pkg::word_t     mem_hi_write_data_i;
    logic              mem_lo_write_enable_i;
    ex_pkg::word_t     mem_lo_write_data_i;
    logic              wb_hi_write_enable_i;
    ex_pkg::word_t     wb_hi_write_data_i;
    logic              wb_lo_write_enable_i;
    ex_pkg::word_t     wb_lo_write_data_i;
    ex_pkg::word_t     hi_read_data_i;
    ex_pkg::word_t     lo_read_data_i;
    logic              valid_o;
    logic              reg_write_enable_o;
    ex_pkg::reg_addr_t reg_write_addr_o;
    ex_pkg::word_t     reg_write_data_o;
    logic              hi_write_enable_o;
    ex_pkg::word_t     hi_write_data_o;
    logic              lo_write_enable_o;
    ex_pkg::word_t     lo_write_data_o;
    logic [31:0]       rng_state;
    int                cycle_count;

    bind stage_ex stage_ex_props stage_ex_props_inst (.*);

    stage_ex stage_ex_inst (.*);

    always #HALF_PERIOD clock_i = ~clock_i;

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // a quarter of the operands are corner values.
    function automatic ex_pkg::word_t pick_operand();
        logic [31:0] r;
        r = next_random();
        case (r[3:0])
            4'd0:    return '0;
            4'd1:    return '1;
            4'd2:    return 32'h8000_0000;
            4'd3:    return 32'h7fff_ffff;
            default: return next_random();
        endcase
    endfunction

    function automatic ex_pkg::alu_op_t pick_operator();
        ex_pkg::alu_op_t op;
        int unsigned     steps;
        op    = op.first();
        steps = next_random() % op.num();
        repeat (steps) op = op.next();
        return op;
    endfunction

    task automatic clear_inputs();
        valid_i               = 1'b0;
        operator_i            = ex_pkg::OP_NOP;
        operand_a_i           = '0;
        operand_b_i           = '0;
        reg_write_enable_i    = 1'b0;
        reg_write_addr_i      = '0;
        mem_hi_write_enable_i = 1'b0;
        mem_hi_write_data_i   = '0;
        mem_lo_write_enable_i = 1'b0;
        mem_lo_write_data_i   = '0;
        wb_hi_write_enable_i  = 1'b0;
        wb_hi_write_data_i    = '0;
        wb_lo_write_enable_i  = 1'b0;
        wb_lo_write_data_i    = '0;
        hi_read_data_i        = '0;
        lo_read_data_i        = '0;
    endtask

    task automatic drive_operation();
        logic [31:0] r;
        r                     = next_random();
        // valid about 80 percent of the time.
        valid_i               = r[7:4] < 4'd13;
        reg_write_enable_i    = r[8] | r[9];
        reg_write_addr_i      = r[14:10];
        mem_hi_write_enable_i = r[0];
        mem_lo_write_enable_i = r[1];
        wb_hi_write_enable_i  = r[2];
        wb_lo_write_enable_i  = r[3];
        operator_i            = pick_operator();
        operand_a_i           = pick_operand();
        operand_b_i           = pick_operand();
        mem_hi_write_data_i   = next_random();
        mem_lo_write_data_i   = next_random();
        wb_hi_write_data_i    = next_random();
        wb_lo_write_data_i    = next_random();
        hi_read_data_i        = next_random();
        lo_read_data_i        = next_random();
    endtask

    initial begin
        rng_state = 32'hd62f_13f7;
        clock_i   = 1'b0;
        arst_n_i  = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clock_i);
        #DRIVE_DELAY;
        arst_n_i = 1'b1;
        for (int n = 0; n < NUM_OPS; n++) begin
            drive_operation();
            @(posedge clock_i);
            #DRIVE_DELAY;
        end
        clear_inputs();
        // the last operation is checked one edge after it is sampled.
        repeat (2) @(posedge clock_i);
        #DRIVE_DELAY;
        if (stage_ex_inst.stage_ex_props_inst.error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "assertion failures were reported");
        end
    end

    initial begin
        wait (stage_ex_inst.stage_ex_props_inst.error_count != 0);
        $display("Something failed");
        $fatal(1, "stopped at the first failing check");
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock_i);
            cycle_count++;
        end
        $display("Something failed");
        $fatal(1, "timeout, the run did not end within %0d cycles", MAX_CYCLES);
    end

endmodule

`default_nettype wire

//--- stage_ex.f
verilog/ex_pkg.sv
verilog/ex_logic_shift_unit.sv
verilog/ex_arith_unit.sv
verilog/ex_mult_unit.sv
verilog/ex_hilo_unit.sv
verilog/stage_ex.sv
dv/stage_ex_props.sv
dv/stage_ex_tb.sv
